// File: verilog/mdu_pkg.sv
package mdu_pkg;

    // data word carried on the CDB and in operands
    typedef logic [31:0] word_t;

    // reorder-buffer id, also used as the wakeup tag
    typedef logic [5:0] rob_id_t;

    typedef logic [1:0] mdu_op_t;

    // operation encodings
    localparam mdu_op_t OP_MUL  = 2'd0;
    localparam mdu_op_t OP_MULH = 2'd1;
    localparam mdu_op_t OP_DIVU = 2'd2;
    localparam mdu_op_t OP_REMU = 2'd3;

    // issue queue sizing
    localparam int IQ_DEPTH       = 4;
    localparam int DISPATCH_WIDTH = 2;

    // number of result buses snooped for wakeup
    localparam int CDB_SNOOP_COUNT = 2;

    // result buffering toward the CDB
    localparam int CDB_FIFO_DEPTH = 2;

endpackage

// File: verilog/mdu_iq_entry.sv
`timescale 1ns/1ps

module mdu_iq_entry (
    input  logic                                              clk,
    input  logic                                              reset_i,
    input  logic                                              flush_i,
    input  logic                                              write_i,
    input  logic                                              fire_i,
    input  mdu_pkg::mdu_op_t                                  op_i,
    input  mdu_pkg::rob_id_t                                  rd_i,
    input  logic             [1:0]                            src_ready_i,
    input  mdu_pkg::rob_id_t [1:0]                            src_tag_i,
    input  mdu_pkg::word_t   [1:0]                            src_data_i,
    input  logic             [mdu_pkg::CDB_SNOOP_COUNT-1:0]   snoop_valid_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::CDB_SNOOP_COUNT-1:0]   snoop_tag_i,
    input  mdu_pkg::word_t   [mdu_pkg::CDB_SNOOP_COUNT-1:0]   snoop_data_i,
    output logic                                              empty_o,
    output logic                                              ready_o,
    output mdu_pkg::mdu_op_t                                  op_o,
    output mdu_pkg::rob_id_t                                  rd_o,
    output mdu_pkg::word_t                                    a_o,
    output mdu_pkg::word_t                                    b_o
);
    import mdu_pkg::*;

    logic          valid_q;
    logic [1:0]    src_rdy_q;
    rob_id_t [1:0] src_tag_q;
    word_t [1:0]   src_data_q;
    mdu_op_t       op_q;
    rob_id_t       rd_q;

    logic [1:0]    src_rdy_d;
    rob_id_t [1:0] src_tag_d;
    word_t [1:0]   src_data_d;

    // take the dispatched source on a write, else the stored one,
    // then let any matching snoop port wake it up
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_rdy_d[s]  = write_i ? src_ready_i[s] : src_rdy_q[s];
            src_tag_d[s]  = write_i ? src_tag_i[s] : src_tag_q[s];
            src_data_d[s] = write_i ? src_data_i[s] : src_data_q[s];
            for (int p = 0; p < CDB_SNOOP_COUNT; p++) begin
                if (!src_rdy_d[s] && snoop_valid_i[p] && snoop_tag_i[p] == src_tag_d[s]) begin
                    src_rdy_d[s]  = 1'b1;
                    src_data_d[s] = snoop_data_i[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q   <= 1'b0;
            src_rdy_q <= '0;
        end else begin
            if (write_i) begin
                valid_q <= 1'b1;
            end else if (fire_i) begin
                valid_q <= 1'b0;
            end
            src_rdy_q <= src_rdy_d;
        end
    end

    always_ff @(posedge clk) begin
        if (write_i) begin
            op_q <= op_i;
            rd_q <= rd_i;
        end
        src_tag_q  <= src_tag_d;
        src_data_q <= src_data_d;
    end

    assign empty_o = !valid_q;
    assign ready_o = valid_q && (&src_rdy_q);
    assign op_o    = op_q;
    assign rd_o    = rd_q;
    assign a_o     = src_data_q[0];
    assign b_o     = src_data_q[1];

endmodule

// File: verilog/mdu_iq.sv
`timescale 1ns/1ps

module mdu_iq (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    input  logic                                                 flush_i,
    input  logic             [mdu_pkg::DISPATCH_WIDTH-1:0]       disp_valid_i,
    input  mdu_pkg::mdu_op_t [mdu_pkg::DISPATCH_WIDTH-1:0]       disp_op_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::DISPATCH_WIDTH-1:0]       disp_rd_i,
    input  logic             [mdu_pkg::DISPATCH_WIDTH-1:0][1:0]  disp_src_ready_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::DISPATCH_WIDTH-1:0][1:0]  disp_src_tag_i,
    input  mdu_pkg::word_t   [mdu_pkg::DISPATCH_WIDTH-1:0][1:0]  disp_src_data_i,
    output logic                                                 disp_ready_o,
    input  logic             [mdu_pkg::CDB_SNOOP_COUNT-1:0]      snoop_valid_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::CDB_SNOOP_COUNT-1:0]      snoop_tag_i,
    input  mdu_pkg::word_t   [mdu_pkg::CDB_SNOOP_COUNT-1:0]      snoop_data_i,
    input  logic                                                 ex_ready_i,
    output logic                                                 ex_valid_o,
    output mdu_pkg::mdu_op_t                                     ex_op_o,
    output mdu_pkg::word_t                                       ex_a_o,
    output mdu_pkg::word_t                                       ex_b_o,
    output mdu_pkg::rob_id_t                                     ex_rd_o
);
    import mdu_pkg::*;

    typedef logic [$clog2(IQ_DEPTH+1)-1:0] cnt_t;

    logic [DISPATCH_WIDTH-1:0] accept;
    logic [IQ_DEPTH-1:0]       empty;
    logic [IQ_DEPTH-1:0]       ready;
    logic [IQ_DEPTH-1:0]       alloc_lo;
    logic [IQ_DEPTH-1:0]       alloc_hi;
    logic [IQ_DEPTH-1:0]       fire_oh;
    logic                      fire_any;
    logic                      fire_take;
    logic                      ex_load;
    cnt_t                      free_cnt_q;
    cnt_t                      free_nxt;
    logic                      disp_ready_q;

    mdu_op_t ent_op [IQ_DEPTH];
    rob_id_t ent_rd [IQ_DEPTH];
    word_t   ent_a [IQ_DEPTH];
    word_t   ent_b [IQ_DEPTH];

    mdu_op_t sel_op;
    rob_id_t sel_rd;
    word_t   sel_a;
    word_t   sel_b;

    logic    ex_valid_q;
    mdu_op_t ex_op_q;
    rob_id_t ex_rd_q;
    word_t   ex_a_q;
    word_t   ex_b_q;

    assign accept = disp_valid_i & {DISPATCH_WIDTH{disp_ready_q}};

    // slot 0 fills from the bottom, slot 1 from the top
    always_comb begin
        alloc_lo = '0;
        alloc_hi = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (empty[i] && alloc_lo == '0) begin
                alloc_lo[i] = 1'b1;
            end
            if (empty[IQ_DEPTH-1-i] && alloc_hi == '0) begin
                alloc_hi[IQ_DEPTH-1-i] = 1'b1;
            end
        end
    end

    // lowest ready entry wins
    always_comb begin
        fire_oh  = '0;
        fire_any = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (ready[i] && !fire_any) begin
                fire_oh[i] = 1'b1;
                fire_any   = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_entry
        logic wr_slot0;
        logic wr_slot1;

        assign wr_slot0 = alloc_lo[i] && accept[0];
        assign wr_slot1 = alloc_hi[i] && accept[1];

        mdu_iq_entry u_entry (
            .clk           (clk),
            .reset_i       (reset_i),
            .flush_i       (flush_i),
            .write_i       (wr_slot0 || wr_slot1),
            .fire_i        (fire_oh[i] && ex_load),
            .op_i          (wr_slot1 ? disp_op_i[1] : disp_op_i[0]),
            .rd_i          (wr_slot1 ? disp_rd_i[1] : disp_rd_i[0]),
            .src_ready_i   (wr_slot1 ? disp_src_ready_i[1] : disp_src_ready_i[0]),
            .src_tag_i     (wr_slot1 ? disp_src_tag_i[1] : disp_src_tag_i[0]),
            .src_data_i    (wr_slot1 ? disp_src_data_i[1] : disp_src_data_i[0]),
            .snoop_valid_i (snoop_valid_i),
            .snoop_tag_i   (snoop_tag_i),
            .snoop_data_i  (snoop_data_i),
            .empty_o       (empty[i]),
            .ready_o       (ready[i]),
            .op_o          (ent_op[i]),
            .rd_o          (ent_rd[i]),
            .a_o           (ent_a[i]),
            .b_o           (ent_b[i])
        );
    end

    always_comb begin
        sel_op = '0;
        sel_rd = '0;
        sel_a  = '0;
        sel_b  = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (fire_oh[i]) begin
                sel_op = ent_op[i];
                sel_rd = ent_rd[i];
                sel_a  = ent_a[i];
                sel_b  = ent_b[i];
            end
        end
    end

    // free entries after this cycle's accepts and fire
    always_comb begin
        free_nxt = free_cnt_q;
        if (fire_take) begin
            free_nxt = free_nxt + cnt_t'(1);
        end
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            if (accept[s]) begin
                free_nxt = free_nxt - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            free_cnt_q   <= cnt_t'(IQ_DEPTH);
            disp_ready_q <= 1'b0;
        end else if (flush_i) begin
            free_cnt_q   <= cnt_t'(IQ_DEPTH);
            disp_ready_q <= 1'b1;
        end else begin
            free_cnt_q   <= free_nxt;
            disp_ready_q <= free_nxt >= cnt_t'(DISPATCH_WIDTH);
        end
    end

    // execute register loads when empty or draining this cycle
    assign ex_load   = !ex_valid_q || ex_ready_i;
    assign fire_take = fire_any && ex_load;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ex_valid_q <= 1'b0;
        end else if (ex_load) begin
            ex_valid_q <= fire_any;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_take) begin
            ex_op_q <= sel_op;
            ex_rd_q <= sel_rd;
            ex_a_q  <= sel_a;
            ex_b_q  <= sel_b;
        end
    end

    assign disp_ready_o = disp_ready_q;
    assign ex_valid_o   = ex_valid_q;
    assign ex_op_o      = ex_op_q;
    assign ex_rd_o      = ex_rd_q;
    assign ex_a_o       = ex_a_q;
    assign ex_b_o       = ex_b_q;

endmodule

// File: verilog/mdu_unit.sv
`timescale 1ns/1ps

module mdu_unit (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             ex_valid_i,
    input  mdu_pkg::mdu_op_t op_i,
    input  mdu_pkg::word_t   a_i,
    input  mdu_pkg::word_t   b_i,
    input  mdu_pkg::rob_id_t rd_i,
    input  logic             res_ready_i,
    output logic             ex_ready_o,
    output logic             res_valid_o,
    output mdu_pkg::rob_id_t res_rd_o,
    output mdu_pkg::word_t   res_data_o
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DIV,
        ST_DONE
    } state_t;

    state_t      state_q;
    logic [5:0]  step_q;
    mdu_op_t     op_q;
    rob_id_t     rd_q;
    word_t       a_q;
    word_t       b_q;
    logic [63:0] prod_q;
    word_t       rem_q;
    word_t       quo_q;
    word_t       res_q;

    logic signed [63:0] prod_s;
    logic [32:0]        rem_sh;
    logic [32:0]        diff;

    assign prod_s = $signed(a_q) * $signed(b_q);

    // one restoring step, borrow shows up in bit 32
    assign rem_sh = {rem_q, quo_q[31]};
    assign diff   = rem_sh - {1'b0, b_q};

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    step_q <= '0;
                    if (ex_valid_i) begin
                        state_q <= (op_i == OP_MUL || op_i == OP_MULH) ? ST_MUL : ST_DIV;
                    end
                end
                ST_MUL: begin
                    step_q <= step_q + 6'd1;
                    if (step_q == 6'd1) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DIV: begin
                    step_q <= step_q + 6'd1;
                    if (step_q == 6'd32) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    if (res_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && ex_valid_i) begin
            op_q  <= op_i;
            rd_q  <= rd_i;
            a_q   <= a_i;
            b_q   <= b_i;
            rem_q <= '0;
            quo_q <= a_i;
        end
        if (state_q == ST_MUL) begin
            if (step_q == 6'd0) begin
                prod_q <= prod_s;
            end else begin
                res_q <= (op_q == OP_MULH) ? prod_q[63:32] : prod_q[31:0];
            end
        end
        if (state_q == ST_DIV) begin
            if (step_q != 6'd32) begin
                rem_q <= diff[32] ? rem_sh[31:0] : diff[31:0];
                quo_q <= {quo_q[30:0], !diff[32]};
            end else if (op_q == OP_REMU) begin
                res_q <= (b_q == '0) ? a_q : rem_q;
            end else begin
                res_q <= (b_q == '0) ? '1 : quo_q;
            end
        end
    end

    assign ex_ready_o  = (state_q == ST_IDLE);
    assign res_valid_o = (state_q == ST_DONE);
    assign res_rd_o    = rd_q;
    assign res_data_o  = res_q;

endmodule

// File: verilog/cdb_fifo.sv
`timescale 1ns/1ps

module cdb_fifo #(
    parameter int WIDTH = 38,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             in_valid_i,
    input  logic [WIDTH-1:0] in_data_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    output logic [WIDTH-1:0] out_data_o,
    input  logic             out_ready_i
);
    typedef logic [(DEPTH > 1 ? $clog2(DEPTH) : 1)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    logic [WIDTH-1:0] mem_q [DEPTH];
    ptr_t             wr_ptr_q;
    ptr_t             rd_ptr_q;
    cnt_t             count_q;
    logic             push;
    logic             pop;

    assign in_ready_o  = (count_q != cnt_t'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
            end
            // occupancy moves only when one side acts alone
            if (push && !pop) begin
                count_q <= count_q + cnt_t'(1);
            end else if (pop && !push) begin
                count_q <= count_q - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

// File: verilog/mdu_cluster_top.sv
`timescale 1ns/1ps

module mdu_cluster_top (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    input  logic                                                 flush_i,
    input  logic             [mdu_pkg::DISPATCH_WIDTH-1:0]       disp_valid_i,
    input  mdu_pkg::mdu_op_t [mdu_pkg::DISPATCH_WIDTH-1:0]       disp_op_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::DISPATCH_WIDTH-1:0]       disp_rd_i,
    input  logic             [mdu_pkg::DISPATCH_WIDTH-1:0][1:0]  disp_src_ready_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::DISPATCH_WIDTH-1:0][1:0]  disp_src_tag_i,
    input  mdu_pkg::word_t   [mdu_pkg::DISPATCH_WIDTH-1:0][1:0]  disp_src_data_i,
    output logic                                                 disp_ready_o,
    input  logic             [mdu_pkg::CDB_SNOOP_COUNT-1:0]      snoop_valid_i,
    input  mdu_pkg::rob_id_t [mdu_pkg::CDB_SNOOP_COUNT-1:0]      snoop_tag_i,
    input  mdu_pkg::word_t   [mdu_pkg::CDB_SNOOP_COUNT-1:0]      snoop_data_i,
    output logic                                                 cdb_valid_o,
    output mdu_pkg::rob_id_t                                     cdb_rd_o,
    output mdu_pkg::word_t                                       cdb_data_o,
    input  logic                                                 cdb_ready_i
);
    import mdu_pkg::*;

    logic    ex_valid;
    logic    ex_ready;
    mdu_op_t ex_op;
    word_t   ex_a;
    word_t   ex_b;
    rob_id_t ex_rd;

    logic    res_valid;
    logic    res_ready;
    rob_id_t res_rd;
    word_t   res_data;

    mdu_iq u_iq (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .disp_valid_i     (disp_valid_i),
        .disp_op_i        (disp_op_i),
        .disp_rd_i        (disp_rd_i),
        .disp_src_ready_i (disp_src_ready_i),
        .disp_src_tag_i   (disp_src_tag_i),
        .disp_src_data_i  (disp_src_data_i),
        .disp_ready_o     (disp_ready_o),
        .snoop_valid_i    (snoop_valid_i),
        .snoop_tag_i      (snoop_tag_i),
        .snoop_data_i     (snoop_data_i),
        .ex_ready_i       (ex_ready),
        .ex_valid_o       (ex_valid),
        .ex_op_o          (ex_op),
        .ex_a_o           (ex_a),
        .ex_b_o           (ex_b),
        .ex_rd_o          (ex_rd)
    );

    mdu_unit u_unit (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .ex_valid_i  (ex_valid),
        .op_i        (ex_op),
        .a_i         (ex_a),
        .b_i         (ex_b),
        .rd_i        (ex_rd),
        .res_ready_i (res_ready),
        .ex_ready_o  (ex_ready),
        .res_valid_o (res_valid),
        .res_rd_o    (res_rd),
        .res_data_o  (res_data)
    );

    // destination id rides above the result word
    cdb_fifo #(
        .WIDTH ($bits(rob_id_t) + $bits(word_t)),
        .DEPTH (CDB_FIFO_DEPTH)
    ) u_cdb_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .in_valid_i  (res_valid),
        .in_data_i   ({res_rd, res_data}),
        .in_ready_o  (res_ready),
        .out_valid_o (cdb_valid_o),
        .out_data_o  ({cdb_rd_o, cdb_data_o}),
        .out_ready_i (cdb_ready_i)
    );

endmodule

// File: dv/mdu_cluster_tb.sv
`timescale 1ns/1ps

module mdu_cluster_tb;
    import mdu_pkg::*;

    typedef enum int {ROB_FREE, ROB_WAITING, ROB_EXPECTED, ROB_FLUSHED} rob_state_t;

    logic               clk;
    logic               reset_i;
    logic               flush_i;
    logic [1:0]         disp_valid_i;
    mdu_op_t [1:0]      disp_op_i;
    rob_id_t [1:0]      disp_rd_i;
    logic [1:0][1:0]    disp_src_ready_i;
    rob_id_t [1:0][1:0] disp_src_tag_i;
    word_t [1:0][1:0]   disp_src_data_i;
    logic               disp_ready_o;
    logic [1:0]         snoop_valid_i;
    rob_id_t [1:0]      snoop_tag_i;
    word_t [1:0]        snoop_data_i;
    logic               cdb_valid_o;
    rob_id_t            cdb_rd_o;
    word_t              cdb_data_o;
    logic               cdb_ready_i;

    // scoreboard, indexed by rob id
    word_t      exp_data [64];
    rob_id_t    wait_tag [64];
    rob_state_t rob_state [64];
    int         outstanding;
    int         next_rob;
    integer     seed;

    mdu_cluster_top u_dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .disp_valid_i     (disp_valid_i),
        .disp_op_i        (disp_op_i),
        .disp_rd_i        (disp_rd_i),
        .disp_src_ready_i (disp_src_ready_i),
        .disp_src_tag_i   (disp_src_tag_i),
        .disp_src_data_i  (disp_src_data_i),
        .disp_ready_o     (disp_ready_o),
        .snoop_valid_i    (snoop_valid_i),
        .snoop_tag_i      (snoop_tag_i),
        .snoop_data_i     (snoop_data_i),
        .cdb_valid_o      (cdb_valid_o),
        .cdb_rd_o         (cdb_rd_o),
        .cdb_data_o       (cdb_data_o),
        .cdb_ready_i      (cdb_ready_i)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // result of one instruction as the ISA defines it
    function automatic word_t model_result(input mdu_op_t op, input word_t a, input word_t b);
        logic [63:0] wide;
        wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        if (op == OP_MUL) return wide[31:0];
        if (op == OP_MULH) return wide[63:32];
        if (b == '0) return (op == OP_DIVU) ? '1 : a;
        return (op == OP_DIVU) ? a / b : a % b;
    endfunction

    // corner values show up about every other draw
    function automatic word_t next_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 32'h8000_0000;
            3'd3: return {29'd0, r[5:3]};
            default: return $random(seed);
        endcase
    endfunction

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_result(input rob_id_t rd, input word_t data);
        if (rob_state[rd] == ROB_FLUSHED) begin
            stop_with_failure($sformatf("rob id %0d came out after a flush", rd));
        end else if (rob_state[rd] == ROB_WAITING) begin
            stop_with_failure($sformatf("rob id %0d came out before its wakeup", rd));
        end else if (rob_state[rd] != ROB_EXPECTED) begin
            stop_with_failure($sformatf("rob id %0d came out but was not outstanding", rd));
        end else begin
            assert (data == exp_data[rd]) else begin
                stop_with_failure($sformatf(
                    "MISMATCH time %0t cdb_data_o rob %0d expected %h actual %h",
                    $time, rd, exp_data[rd], data));
            end
            rob_state[rd] = ROB_FREE;
            outstanding--;
        end
    endtask

    // a transfer seen at the falling edge completes at the next rising edge
    always @(negedge clk) begin
        if (!reset_i && cdb_valid_o && cdb_ready_i) begin
            check_result(cdb_rd_o, cdb_data_o);
        end
    end

    a_reset_quiet: assert property (@(posedge clk) reset_i |=> !cdb_valid_o)
        else stop_with_failure("cdb_valid_o was high after a reset cycle");

    a_flush_clears: assert property (@(posedge clk) disable iff (reset_i) flush_i |=> !cdb_valid_o)
        else stop_with_failure("cdb_valid_o was still high the cycle after flush_i");

    a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
        (cdb_valid_o && !cdb_ready_i && !flush_i)
            |=> (cdb_valid_o && $stable(cdb_rd_o) && $stable(cdb_data_o)))
        else stop_with_failure("CDB output dropped or changed while cdb_ready_i was low");

    task automatic wait_disp_ready(input int limit, output bit ok);
        int n;
        n = 0;
        while (!disp_ready_o && n < limit) begin
            step_cycles(1);
            n++;
        end
        ok = disp_ready_o;
    endtask

    task automatic wait_cdb_valid(input int limit);
        int n;
        n = 0;
        while (!cdb_valid_o && n < limit) begin
            step_cycles(1);
            n++;
        end
        if (!cdb_valid_o) begin
            stop_with_failure("timed out waiting for cdb_valid_o");
        end
    endtask

    // wait_src selects a source that waits on tag, or -1 for none
    task automatic fill_slot(input int slot, input mdu_op_t op, input word_t a, input word_t b,
                             input int wait_src, input rob_id_t tag);
        rob_id_t rd;
        if (next_rob > 63) begin
            stop_with_failure("testbench ran out of unused rob ids");
        end
        rd = rob_id_t'(next_rob);
        next_rob++;
        disp_valid_i[slot]       = 1'b1;
        disp_op_i[slot]          = op;
        disp_rd_i[slot]          = rd;
        disp_src_ready_i[slot]   = 2'b11;
        disp_src_tag_i[slot]     = '0;
        disp_src_data_i[slot][0] = a;
        disp_src_data_i[slot][1] = b;
        if (wait_src >= 0) begin
            // stale data, the snoop must replace it
            disp_src_ready_i[slot][wait_src] = 1'b0;
            disp_src_tag_i[slot][wait_src]   = tag;
            disp_src_data_i[slot][wait_src]  = ~disp_src_data_i[slot][wait_src];
        end
        exp_data[rd]  = model_result(op, a, b);
        wait_tag[rd]  = tag;
        rob_state[rd] = (wait_src >= 0) ? ROB_WAITING : ROB_EXPECTED;
        outstanding++;
    endtask

    task automatic open_dispatch();
        bit ok;
        wait_disp_ready(400, ok);
        if (!ok) begin
            stop_with_failure("timed out waiting for disp_ready_o");
        end
    endtask

    task automatic close_dispatch();
        step_cycles(1);
        disp_valid_i = '0;
    endtask

    task automatic send_pair(input mdu_op_t op0, input word_t a0, input word_t b0,
                             input mdu_op_t op1, input word_t a1, input word_t b1);
        open_dispatch();
        fill_slot(0, op0, a0, b0, -1, '0);
        fill_slot(1, op1, a1, b1, -1, '0);
        close_dispatch();
    endtask

    task automatic drive_snoop(input int port, input rob_id_t tag, input word_t data);
        snoop_valid_i[port] = 1'b1;
        snoop_tag_i[port]   = tag;
        snoop_data_i[port]  = data;
        for (int r = 0; r < 64; r++) begin
            if (rob_state[r] == ROB_WAITING && wait_tag[r] == tag) begin
                rob_state[r] = ROB_EXPECTED;
            end
        end
        step_cycles(1);
        snoop_valid_i[port] = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (outstanding != 0 && n < limit) begin
            step_cycles(1);
            n++;
        end
        if (outstanding != 0) begin
            stop_with_failure($sformatf("timed out with %0d results outstanding", outstanding));
        end
    endtask

    initial begin
        logic [31:0] r;
        word_t       a;
        word_t       b;
        bit          ok;
        bit          stalled;
        int          n;
        seed             = 32'hb0c6;
        reset_i          = 1'b1;
        flush_i          = 1'b0;
        disp_valid_i     = '0;
        disp_op_i        = '0;
        disp_rd_i        = '0;
        disp_src_ready_i = '0;
        disp_src_tag_i   = '0;
        disp_src_data_i  = '0;
        snoop_valid_i    = '0;
        snoop_tag_i      = '0;
        snoop_data_i     = '0;
        cdb_ready_i      = 1'b1;
        outstanding      = 0;
        next_rob         = 0;
        for (int i = 0; i < 64; i++) begin
            rob_state[i] = ROB_FREE;
        end
        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // out of reset: quiet CDB, dispatch opens quickly
        n = 0;
        while (!disp_ready_o && n < 2) begin
            step_cycles(1);
            n++;
        end
        if (!disp_ready_o) begin
            stop_with_failure("disp_ready_o not high within two cycles of reset");
        end
        assert (!cdb_valid_o) else stop_with_failure("cdb_valid_o high right after reset");

        // multiplies in pairs
        repeat (8) begin
            r = $random(seed);
            send_pair(r[0] ? OP_MULH : OP_MUL, next_operand(), next_operand(),
                      r[1] ? OP_MULH : OP_MUL, next_operand(), next_operand());
        end
        wait_drain(400);

        // divides with zero divisors and all-ones operands
        send_pair(OP_DIVU, next_operand(), '0, OP_REMU, next_operand(), '0);
        send_pair(OP_DIVU, '1, '1, OP_REMU, '1, 32'h10);
        repeat (4) begin
            r = $random(seed);
            send_pair(mdu_op_t'({1'b1, r[0]}), next_operand(), next_operand(),
                      mdu_op_t'({1'b1, r[1]}), next_operand(), next_operand());
        end
        wait_drain(2000);

        // sources waiting on a wakeup
        // odd multiplicand so a stale b always shows in the product
        a = $random(seed) | 32'h1;
        b = $random(seed);
        open_dispatch();
        fill_slot(0, OP_MUL, a, b, 1, 6'h3a);
        fill_slot(1, OP_DIVU, b, 32'd7, 0, 6'h3b);
        close_dispatch();
        r = $random(seed);
        step_cycles(3 + int'(r[2:0]));
        drive_snoop(0, 6'h2a, next_operand());
        step_cycles(4);
        drive_snoop(1, 6'h3a, b);
        drive_snoop(0, 6'h3b, b);
        wait_drain(400);

        // back-pressure from the CDB
        cdb_ready_i = 1'b0;
        stalled     = 1'b0;
        n           = 0;
        while (!stalled && n < 8) begin
            wait_disp_ready(60, ok);
            if (!ok) begin
                stalled = 1'b1;
            end else begin
                r = $random(seed);
                fill_slot(0, r[0] ? OP_MULH : OP_MUL, next_operand(), next_operand(), -1, '0);
                fill_slot(1, r[1] ? OP_MULH : OP_MUL, next_operand(), next_operand(), -1, '0);
                close_dispatch();
                n++;
            end
        end
        if (!stalled) begin
            stop_with_failure("disp_ready_o never fell while cdb_ready_i was low");
        end
        step_cycles(10);
        cdb_ready_i = 1'b1;
        wait_drain(1000);

        // flush with results held on the CDB and divides in flight
        cdb_ready_i = 1'b0;
        send_pair(OP_MUL, next_operand(), next_operand(),
                  OP_MULH, next_operand(), next_operand());
        send_pair(OP_DIVU, next_operand(), 32'd3, OP_REMU, next_operand(), 32'd5);
        send_pair(OP_DIVU, '1, 32'd9, OP_REMU, 32'h1234_5678, 32'd10);
        wait_cdb_valid(100);
        flush_i = 1'b1;
        for (int i = 0; i < 64; i++) begin
            if (rob_state[i] == ROB_EXPECTED || rob_state[i] == ROB_WAITING) begin
                rob_state[i] = ROB_FLUSHED;
            end
        end
        outstanding = 0;
        step_cycles(1);
        flush_i     = 1'b0;
        cdb_ready_i = 1'b1;
        step_cycles(80);
        send_pair(OP_MUL, next_operand(), next_operand(), OP_REMU, next_operand(), next_operand());
        send_pair(OP_DIVU, next_operand(), next_operand(), OP_MULH, '1, 32'h8000_0000);
        wait_drain(1000);

        if (outstanding != 0) begin
            stop_with_failure("results still outstanding at the end of the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: sources.f
verilog/mdu_pkg.sv
verilog/mdu_iq_entry.sv
verilog/mdu_iq.sv
verilog/mdu_unit.sv
verilog/cdb_fifo.sv
verilog/mdu_cluster_top.sv
dv/mdu_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the cluster testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module mdu_cluster_tb -o mdu_cluster_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/mdu_cluster_sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
